//--- Makefile
# Verilator build and run for the histogram subsystem

VERILATOR ?= verilator
TOP       ?= hist_build_tb
FILELIST  ?= hist_build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass line shows up in the simulation output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q '^RESULT: PASS$$'

clean:
	rm -rf $(OBJ_DIR)

//--- hist_build.f
source/hist_geom_pkg.sv
source/wb_map_pkg.sv
source/frame_sequencer.sv
source/coarse_hist_builder.sv
source/fine_hist_builder.sv
source/peak_refiner.sv
source/hist_build_top.sv
testbench/tb_clock_gen.sv
testbench/hist_build_tb.sv

//--- source/coarse_hist_builder.sv
`timescale 1ns/1ns
`default_nettype none

module coarse_hist_builder (
    input  logic                                    clk,
    input  logic                                    combin_res,
    input  logic                                    accept,
    input  logic [hist_geom_pkg::PIXEL_BITS-1:0]    pixel,
    input  hist_geom_pkg::tdc_code_u                code,
    input  logic                                    clear_start,
    output logic [hist_geom_pkg::PIXEL_NUM*hist_geom_pkg::COARSE_BITS-1:0] peak_bins
);
    import hist_geom_pkg::*;

    logic [COUNT_BITS-1:0]  bin_cnt [PIXEL_NUM][COARSE_BINS];
    // running peak of every pixel
    logic [COARSE_BITS-1:0] peak_bin [PIXEL_NUM];
    logic [COUNT_BITS-1:0]  peak_cnt [PIXEL_NUM];
    logic                   clr_active;
    logic [COARSE_BITS-1:0] clr_bin;
    logic [COARSE_BITS-1:0] cur_bin;
    logic [COUNT_BITS-1:0]  cur_cnt;
    logic [COUNT_BITS-1:0]  next_cnt;
    logic                   new_peak;

    always_comb begin
        cur_bin  = code.pair.coarse;
        cur_cnt  = bin_cnt[pixel][cur_bin];
        // hold at full scale
        next_cnt = (cur_cnt == '1) ? cur_cnt : cur_cnt + 1'b1;
        // lower bin wins on equal counts
        new_peak = (next_cnt > peak_cnt[pixel])
                || ((next_cnt == peak_cnt[pixel]) && (cur_bin < peak_bin[pixel]));
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                for (int b = 0; b < COARSE_BINS; b++) begin
                    bin_cnt[p][b] <= '0;
                end
                peak_bin[p] <= '0;
                peak_cnt[p] <= '0;
            end
            clr_active <= 1'b0;
            clr_bin    <= '0;
        end else begin
            if (clear_start) begin
                clr_active <= 1'b1;
                clr_bin    <= '0;
                for (int p = 0; p < PIXEL_NUM; p++) begin
                    peak_bin[p] <= '0;
                    peak_cnt[p] <= '0;
                end
            end else if (clr_active) begin
                // same bin of every pixel per cycle
                for (int p = 0; p < PIXEL_NUM; p++) begin
                    bin_cnt[p][clr_bin] <= '0;
                end
                clr_bin <= clr_bin + 1'b1;
                if (clr_bin == COARSE_BINS - 1) begin
                    clr_active <= 1'b0;
                end
            end
            if (accept) begin
                bin_cnt[pixel][cur_bin] <= next_cnt;
                if (new_peak) begin
                    peak_bin[pixel] <= cur_bin;
                    peak_cnt[pixel] <= next_cnt;
                end
            end
        end
    end

    // flatten for the refiner
    always_comb begin
        for (int p = 0; p < PIXEL_NUM; p++) begin
            peak_bins[p*COARSE_BITS +: COARSE_BITS] = peak_bin[p];
        end
    end

endmodule

`default_nettype wire

//--- source/fine_hist_builder.sv
`timescale 1ns/1ns
`default_nettype none

module fine_hist_builder (
    input  logic                                    clk,
    input  logic                                    combin_res,
    input  logic                                    accept,
    input  logic [hist_geom_pkg::PIXEL_BITS-1:0]    pixel,
    input  hist_geom_pkg::tdc_code_u                code,
    input  logic                                    clear_start,
    input  logic [hist_geom_pkg::PIXEL_BITS-1:0]    scan_pixel,
    input  hist_geom_pkg::tdc_code_u                scan_bin,
    output logic [hist_geom_pkg::COUNT_BITS-1:0]    scan_count,
    output logic                                    clear_busy
);
    import hist_geom_pkg::*;

    // pixel in the upper address bits, fine bin below
    logic [COUNT_BITS-1:0]            hist_mem [PIXEL_NUM*FINE_BINS];
    logic [PIXEL_BITS+CODE_BITS-1:0]  wr_addr;
    logic [COUNT_BITS-1:0]            cur_cnt;
    logic [COUNT_BITS-1:0]            next_cnt;
    logic [CODE_BITS-1:0]             clr_bin;

    always_comb begin
        wr_addr  = {pixel, code.fine};
        cur_cnt  = hist_mem[wr_addr];
        next_cnt = (cur_cnt == '1) ? cur_cnt : cur_cnt + 1'b1;
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int i = 0; i < PIXEL_NUM*FINE_BINS; i++) begin
                hist_mem[i] <= '0;
            end
            clear_busy <= 1'b0;
            clr_bin    <= '0;
        end else begin
            if (clear_start) begin
                clear_busy <= 1'b1;
                clr_bin    <= '0;
            end else if (clear_busy) begin
                // one bin of all pixels per cycle, 256 cycles in all
                for (int p = 0; p < PIXEL_NUM; p++) begin
                    hist_mem[p*FINE_BINS + int'(clr_bin)] <= '0;
                end
                clr_bin <= clr_bin + 1'b1;
                if (clr_bin == FINE_BINS - 1) begin
                    clear_busy <= 1'b0;
                end
            end
            if (accept) begin
                hist_mem[wr_addr] <= next_cnt;
            end
        end
    end

    // combinational scan read
    assign scan_count = hist_mem[{scan_pixel, scan_bin.fine}];

endmodule

`default_nettype wire

//--- source/frame_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module frame_sequencer (
    input  logic                                    clk,
    input  logic                                    combin_res,
    input  logic                                    code_valid,
    input  logic                                    clear_busy,
    input  logic                                    scan_busy,
    output logic                                    ready,
    output logic                                    accept,
    output logic [hist_geom_pkg::PIXEL_BITS-1:0]    pixel,
    output logic                                    scan_start,
    output logic                                    clear_start,
    output logic [wb_map_pkg::FRAME_BITS-1:0]       frame_count
);
    import hist_geom_pkg::*;

    logic [CODE_CNT_BITS-1:0] code_cnt;
    logic [ACQ_BITS-1:0]      acq_cnt;
    // low ready and low clearing means the scan phase
    logic                     clearing;
    logic                     last_code;

    // codes offered while ready is low are dropped
    assign accept = code_valid && ready;

    assign last_code = (code_cnt == CODES_PER_PIXEL - 1) && (pixel == PIXEL_NUM - 1)
                    && (acq_cnt == ACQ_NUM - 1);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            code_cnt    <= '0;
            pixel       <= '0;
            acq_cnt     <= '0;
            ready       <= 1'b1;
            clearing    <= 1'b0;
            scan_start  <= 1'b0;
            clear_start <= 1'b0;
            frame_count <= '0;
        end else begin
            scan_start  <= 1'b0;
            clear_start <= 1'b0;
            if (accept) begin
                // nested counters, all wrap together on the last code
                if (code_cnt == CODES_PER_PIXEL - 1) begin
                    code_cnt <= '0;
                    if (pixel == PIXEL_NUM - 1) begin
                        pixel <= '0;
                        if (acq_cnt == ACQ_NUM - 1) begin
                            acq_cnt <= '0;
                        end else begin
                            acq_cnt <= acq_cnt + 1'b1;
                        end
                    end else begin
                        pixel <= pixel + 1'b1;
                    end
                end else begin
                    code_cnt <= code_cnt + 1'b1;
                end
                if (last_code) begin
                    ready       <= 1'b0;
                    scan_start  <= 1'b1;
                    frame_count <= frame_count + 1'b1;
                end
            end else if (!ready && !clearing && !scan_start && !scan_busy) begin
                // scan_busy only rises the cycle after scan_start
                clearing    <= 1'b1;
                clear_start <= 1'b1;
            end else if (clearing && !clear_start && !clear_busy) begin
                clearing <= 1'b0;
                ready    <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/hist_build_top.sv
`timescale 1ns/1ns
`default_nettype none

module hist_build_top (
    input  logic                                    clk,
    input  logic                                    combin_res,
    input  logic                                    code_valid,
    input  hist_geom_pkg::tdc_code_u                code,
    input  logic                                    cyc,
    input  logic                                    stb,
    input  logic                                    we,
    input  logic [wb_map_pkg::WB_ADDR_BITS-1:0]     adr,
    input  logic [wb_map_pkg::WB_DATA_BITS-1:0]     dat_w,
    output logic                                    ready,
    output logic                                    frame_done,
    output logic [wb_map_pkg::WB_DATA_BITS-1:0]     dat_r,
    output logic                                    ack
);
    import hist_geom_pkg::*;
    import wb_map_pkg::*;

    logic                             accept;
    logic [PIXEL_BITS-1:0]            pixel;
    logic                             scan_start;
    logic                             scan_busy;
    logic                             clear_start;
    logic                             clear_busy;
    logic [FRAME_BITS-1:0]            frame_count;
    logic [PIXEL_BITS-1:0]            scan_pixel;
    tdc_code_u                        scan_bin;
    logic [COUNT_BITS-1:0]            scan_count;
    logic [PIXEL_NUM*COARSE_BITS-1:0] peak_bins;

    frame_sequencer u_sequencer (
        .clk         (clk),
        .combin_res  (combin_res),
        .code_valid  (code_valid),
        .clear_busy  (clear_busy),
        .scan_busy   (scan_busy),
        .ready       (ready),
        .accept      (accept),
        .pixel       (pixel),
        .scan_start  (scan_start),
        .clear_start (clear_start),
        .frame_count (frame_count)
    );

    // coarse clear is shorter than the fine one, only clear_busy is followed
    coarse_hist_builder u_coarse (
        .clk         (clk),
        .combin_res  (combin_res),
        .accept      (accept),
        .pixel       (pixel),
        .code        (code),
        .clear_start (clear_start),
        .peak_bins   (peak_bins)
    );

    fine_hist_builder u_fine (
        .clk         (clk),
        .combin_res  (combin_res),
        .accept      (accept),
        .pixel       (pixel),
        .code        (code),
        .clear_start (clear_start),
        .scan_pixel  (scan_pixel),
        .scan_bin    (scan_bin),
        .scan_count  (scan_count),
        .clear_busy  (clear_busy)
    );

    // bus write data has no destination, writes are only acknowledged
    peak_refiner u_refiner (
        .clk         (clk),
        .combin_res  (combin_res),
        .scan_start  (scan_start),
        .peak_bins   (peak_bins),
        .scan_count  (scan_count),
        .frame_count (frame_count),
        .cyc         (cyc),
        .stb         (stb),
        .we          (we),
        .adr         (adr),
        .dat_r       (dat_r),
        .ack         (ack),
        .scan_busy   (scan_busy),
        .scan_pixel  (scan_pixel),
        .scan_bin    (scan_bin),
        .frame_done  (frame_done)
    );

endmodule

`default_nettype wire

//--- source/hist_geom_pkg.sv
`default_nettype none

package hist_geom_pkg;

    // time code and its two fields
    localparam int CODE_BITS   = 8;
    localparam int COARSE_BITS = 4;
    localparam int OFFSET_BITS = 4;
    localparam int FINE_BINS   = 256;
    localparam int COARSE_BINS = 16;

    // pixel group
    localparam int PIXEL_NUM  = 4;
    localparam int PIXEL_BITS = 2;

    // acquisition structure of one frame
    localparam int CODES_PER_PIXEL = 3;
    localparam int CODE_CNT_BITS   = $clog2(CODES_PER_PIXEL);
    localparam int ACQ_NUM         = 5;
    localparam int ACQ_BITS        = $clog2(ACQ_NUM);

    // counts saturate at all ones
    localparam int COUNT_BITS = 8;

    // one cycle per fine bin in every coarse window, plus read and finish cycles
    localparam int SCAN_CYCLES = PIXEL_NUM * (1 << OFFSET_BITS) + 2;
    localparam int SCAN_BITS   = $clog2(SCAN_CYCLES);

    // one code word, seen as a fine index or as a coarse bin plus offset
    typedef union packed {
        logic [CODE_BITS-1:0] fine;
        struct packed {
            logic [COARSE_BITS-1:0] coarse;
            logic [OFFSET_BITS-1:0] offset;
        } pair;
    } tdc_code_u;

endpackage

`default_nettype wire

//--- source/peak_refiner.sv
`timescale 1ns/1ns
`default_nettype none

module peak_refiner (
    input  logic                                    clk,
    input  logic                                    combin_res,
    input  logic                                    scan_start,
    input  logic [hist_geom_pkg::PIXEL_NUM*hist_geom_pkg::COARSE_BITS-1:0] peak_bins,
    input  logic [hist_geom_pkg::COUNT_BITS-1:0]    scan_count,
    input  logic [wb_map_pkg::FRAME_BITS-1:0]       frame_count,
    input  logic                                    cyc,
    input  logic                                    stb,
    input  logic                                    we,
    input  logic [wb_map_pkg::WB_ADDR_BITS-1:0]     adr,
    output logic [wb_map_pkg::WB_DATA_BITS-1:0]     dat_r,
    output logic                                    ack,
    output logic                                    scan_busy,
    output logic [hist_geom_pkg::PIXEL_BITS-1:0]    scan_pixel,
    output hist_geom_pkg::tdc_code_u                scan_bin,
    output logic                                    frame_done
);
    import hist_geom_pkg::*;
    import wb_map_pkg::*;

    logic [SCAN_BITS-1:0]    step;
    // read stage, one cycle behind the scan address
    logic                    cmp_valid;
    logic [PIXEL_BITS-1:0]   cmp_pixel;
    logic [OFFSET_BITS-1:0]  cmp_off;
    logic [COUNT_BITS-1:0]   cmp_count;
    logic [OFFSET_BITS-1:0]  best_off;
    logic [COUNT_BITS-1:0]   best_count;
    logic                    take_new;
    tdc_code_u               res_code_u;
    logic [CODE_BITS-1:0]    res_code  [PIXEL_NUM];
    logic [COUNT_BITS-1:0]   res_count [PIXEL_NUM];
    logic                    done;
    logic                    ack_seen;
    logic [WB_ADDR_BITS-1:0] rel_adr;
    logic [WB_DATA_BITS-1:0] rd_word;

    // walk offsets inside the coarse peak window of each pixel
    assign scan_pixel = step[OFFSET_BITS +: PIXEL_BITS];

    always_comb begin
        scan_bin.pair.coarse = peak_bins[scan_pixel*COARSE_BITS +: COARSE_BITS];
        scan_bin.pair.offset = step[OFFSET_BITS-1:0];
        // first maximum is kept
        take_new = (cmp_off == '0) || (cmp_count > best_count);
        res_code_u.pair.coarse = peak_bins[cmp_pixel*COARSE_BITS +: COARSE_BITS];
        res_code_u.pair.offset = take_new ? cmp_off : best_off;
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            step       <= '0;
            scan_busy  <= 1'b0;
            cmp_valid  <= 1'b0;
            done       <= 1'b0;
            frame_done <= 1'b0;
            best_off   <= '0;
            best_count <= '0;
            ack        <= 1'b0;
            ack_seen   <= 1'b0;
            for (int p = 0; p < PIXEL_NUM; p++) begin
                res_code[p]  <= '0;
                res_count[p] <= '0;
            end
        end else begin
            frame_done <= 1'b0;
            cmp_valid  <= scan_busy && (step < SCAN_CYCLES - 2);
            if (scan_start) begin
                scan_busy <= 1'b1;
                step      <= '0;
                done      <= 1'b0;
            end else if (scan_busy) begin
                if (step == SCAN_CYCLES - 1) begin
                    scan_busy  <= 1'b0;
                    done       <= 1'b1;
                    frame_done <= 1'b1;
                end else begin
                    step <= step + 1'b1;
                end
            end
            if (cmp_valid) begin
                if (take_new) begin
                    best_off   <= cmp_off;
                    best_count <= cmp_count;
                end
                // last offset of the window closes the pixel
                if (cmp_off == '1) begin
                    res_code[cmp_pixel]  <= res_code_u.fine;
                    res_count[cmp_pixel] <= take_new ? cmp_count : best_count;
                end
            end
            // one ack per request, then wait for stb to drop
            ack      <= cyc && stb && !ack && !ack_seen;
            ack_seen <= cyc && stb && (ack || ack_seen);
        end
    end

    always_ff @(posedge clk) begin
        cmp_pixel <= scan_pixel;
        cmp_off   <= scan_bin.pair.offset;
        cmp_count <= scan_count;
        // writes return zero and change nothing
        if (cyc && stb && !ack && !ack_seen) begin
            dat_r <= we ? '0 : rd_word;
        end
    end

    // register map, unmapped words read zero
    always_comb begin
        rel_adr = adr - ADDR_RESULT_BASE;
        rd_word = '0;
        if (adr == ADDR_STATUS) begin
            rd_word[STATUS_DONE_BIT] = done;
            rd_word[STATUS_FRAME_LSB +: FRAME_BITS] = frame_count;
        end else if ((adr >= ADDR_RESULT_BASE) && (rel_adr < PIXEL_NUM)) begin
            rd_word[RESULT_CODE_LSB +: CODE_BITS]   = res_code[rel_adr[PIXEL_BITS-1:0]];
            rd_word[RESULT_COUNT_LSB +: COUNT_BITS] = res_count[rel_adr[PIXEL_BITS-1:0]];
        end
    end

endmodule

`default_nettype wire

//--- source/wb_map_pkg.sv
`default_nettype none

package wb_map_pkg;

    // bus widths
    localparam int WB_ADDR_BITS = 4;
    localparam int WB_DATA_BITS = 32;

    // word addresses
    localparam logic [WB_ADDR_BITS-1:0] ADDR_STATUS      = 4'd0;
    // pixel p result sits at base plus p
    localparam logic [WB_ADDR_BITS-1:0] ADDR_RESULT_BASE = 4'd1;

    // status word
    localparam int STATUS_DONE_BIT  = 0;
    localparam int STATUS_FRAME_LSB = 8;
    localparam int FRAME_BITS       = 8;

    // result word
    localparam int RESULT_CODE_LSB  = 0;
    localparam int RESULT_COUNT_LSB = 16;

endpackage

`default_nettype wire

//--- testbench/hist_build_tb.sv
`timescale 1ns/1ns
`default_nettype none

module hist_build_tb;
    import hist_geom_pkg::*;
    import wb_map_pkg::*;

    localparam int ACK_LIMIT   = 8;
    localparam int DONE_LIMIT  = 400;
    localparam int READY_LIMIT = 800;
    // kinds of frames
    localparam int KIND_RANDOM = 0;
    localparam int KIND_SINGLE = 1;
    localparam int KIND_TIE    = 2;

    logic                    clk;
    logic                    combin_res;
    logic                    code_valid;
    tdc_code_u               code;
    logic                    cyc;
    logic                    stb;
    logic                    we;
    logic [WB_ADDR_BITS-1:0] adr;
    logic [WB_DATA_BITS-1:0] dat_w;
    logic                    ready;
    logic                    frame_done;
    logic [WB_DATA_BITS-1:0] dat_r;
    logic                    ack;

    // shadow histograms with unbounded counts
    int unsigned             fine_hist   [PIXEL_NUM][FINE_BINS];
    int unsigned             coarse_hist [PIXEL_NUM][COARSE_BINS];
    // expected result words of the last checked frame
    logic [WB_DATA_BITS-1:0] last_results [PIXEL_NUM];
    logic [31:0]             lcg_state;
    logic [FRAME_BITS-1:0]   frames_seen;

    tb_clock_gen #(.PERIOD(4)) u_clock (.clk(clk));

    hist_build_top UUT (
        .clk        (clk),
        .combin_res (combin_res),
        .code_valid (code_valid),
        .code       (code),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .adr        (adr),
        .dat_w      (dat_w),
        .ready      (ready),
        .frame_done (frame_done),
        .dat_r      (dat_r),
        .ack        (ack)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // saturating view of a shadow count
    function automatic logic [COUNT_BITS-1:0] sat_count(input int unsigned n);
        return (n >= (1 << COUNT_BITS)) ? '1 : n[COUNT_BITS-1:0];
    endfunction

    // expected result word of one pixel
    function automatic logic [WB_DATA_BITS-1:0] ref_result(input int p);
        int                      best_c;
        int                      best_f;
        int                      b;
        int                      base;
        tdc_code_u               c;
        logic [WB_DATA_BITS-1:0] word;
        // lowest coarse bin among the largest
        best_c = 0;
        for (b = 1; b < COARSE_BINS; b++) begin
            if (sat_count(coarse_hist[p][b]) > sat_count(coarse_hist[p][best_c])) begin
                best_c = b;
            end
        end
        // lowest fine bin inside that window
        base   = best_c * (1 << OFFSET_BITS);
        best_f = 0;
        for (b = 1; b < (1 << OFFSET_BITS); b++) begin
            if (sat_count(fine_hist[p][base + b]) > sat_count(fine_hist[p][base + best_f])) begin
                best_f = b;
            end
        end
        c.pair.coarse = best_c[COARSE_BITS-1:0];
        c.pair.offset = best_f[OFFSET_BITS-1:0];
        word = '0;
        word[RESULT_CODE_LSB +: CODE_BITS]   = c.fine;
        word[RESULT_COUNT_LSB +: COUNT_BITS] = sat_count(fine_hist[p][base + best_f]);
        return word;
    endfunction

    // equal coarse counts in two windows and equal fine counts in the lower one
    function automatic tdc_code_u tie_code(input int p, input int n);
        tdc_code_u c;
        if (n < 6) begin
            c.pair.coarse = 4'(10 + p);
            c.pair.offset = 4'(n);
        end else if (n < 9) begin
            c.pair.coarse = 4'hf;
            c.pair.offset = 4'h0;
        end else begin
            // higher offset fills first
            c.pair.coarse = 4'(2 + p);
            c.pair.offset = (n % 2 == 1) ? 4'hb : 4'h4;
        end
        return c;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [WB_DATA_BITS-1:0] got,
                              input logic [WB_DATA_BITS-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_result(input int p, input logic [WB_DATA_BITS-1:0] got,
                                input logic [WB_DATA_BITS-1:0] exp);
        tdc_code_u             got_code;
        tdc_code_u             exp_code;
        logic [COUNT_BITS-1:0] got_cnt;
        logic [COUNT_BITS-1:0] exp_cnt;
        got_code = got[RESULT_CODE_LSB +: CODE_BITS];
        exp_code = exp[RESULT_CODE_LSB +: CODE_BITS];
        got_cnt  = got[RESULT_COUNT_LSB +: COUNT_BITS];
        exp_cnt  = exp[RESULT_COUNT_LSB +: COUNT_BITS];
        if (got_code !== exp_code) begin
            fail_run($sformatf("mismatch result[%0d].code got 0x%02h expected 0x%02h",
                               p, got_code.fine, exp_code.fine));
        end
        if (got_cnt !== exp_cnt) begin
            fail_run($sformatf("mismatch result[%0d].count got 0x%02h expected 0x%02h",
                               p, got_cnt, exp_cnt));
        end
        // unused bits too
        check_word($sformatf("result[%0d]", p), got, exp);
    endtask

    task automatic check_status(input logic [WB_DATA_BITS-1:0] got, input logic exp_done,
                                input logic [FRAME_BITS-1:0] exp_frame);
        logic [WB_DATA_BITS-1:0] exp;
        exp = '0;
        exp[STATUS_DONE_BIT] = exp_done;
        exp[STATUS_FRAME_LSB +: FRAME_BITS] = exp_frame;
        if (got[STATUS_DONE_BIT] !== exp_done) begin
            fail_run($sformatf("mismatch status.done got 0x%0h expected 0x%0h",
                               got[STATUS_DONE_BIT], exp_done));
        end
        if (got[STATUS_FRAME_LSB +: FRAME_BITS] !== exp_frame) begin
            fail_run($sformatf("mismatch status.frame got 0x%02h expected 0x%02h",
                               got[STATUS_FRAME_LSB +: FRAME_BITS], exp_frame));
        end
        check_word("status", got, exp);
    endtask

    // one classic cycle where ack must stay a single cycle while stb is held
    task automatic bus_cycle(input logic wr, input logic [WB_ADDR_BITS-1:0] addr,
                             input logic [WB_DATA_BITS-1:0] wdata,
                             output logic [WB_DATA_BITS-1:0] rdata);
        int   n;
        logic seen;
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= wr;
        adr   <= addr;
        dat_w <= wdata;
        seen = 1'b0;
        for (n = 0; n < ACK_LIMIT && !seen; n++) begin
            @(negedge clk);
            seen = ack;
        end
        if (!seen) begin
            fail_run($sformatf("no ack for bus request at address 0x%0h", addr));
        end
        rdata = dat_r;
        @(negedge clk);
        if (ack) begin
            fail_run("ack stayed high for more than one cycle");
        end
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
        @(negedge clk);
        if (ack) begin
            fail_run("ack rose again before stb dropped");
        end
    endtask

    task automatic bus_read(input logic [WB_ADDR_BITS-1:0] addr,
                            output logic [WB_DATA_BITS-1:0] data);
        bus_cycle(1'b0, addr, '0, data);
    endtask

    task automatic bus_write(input logic [WB_ADDR_BITS-1:0] addr,
                             input logic [WB_DATA_BITS-1:0] data);
        logic [WB_DATA_BITS-1:0] unused;
        bus_cycle(1'b1, addr, data, unused);
    endtask

    task automatic wait_ready();
        int   n;
        logic seen;
        seen = 1'b0;
        for (n = 0; n < READY_LIMIT && !seen; n++) begin
            @(negedge clk);
            seen = ready;
        end
        if (!seen) begin
            fail_run("timeout waiting for ready");
        end
    endtask

    task automatic wait_frame_done();
        int   n;
        logic seen;
        seen = 1'b0;
        for (n = 0; n < DONE_LIMIT && !seen; n++) begin
            @(negedge clk);
            seen = frame_done;
        end
        if (!seen) begin
            fail_run("timeout waiting for frame_done");
        end
        // single cycle pulse
        @(negedge clk);
        if (frame_done) begin
            fail_run("frame_done stayed high for more than one cycle");
        end
    endtask

    task automatic clear_model();
        for (int p = 0; p < PIXEL_NUM; p++) begin
            for (int b = 0; b < FINE_BINS; b++) begin
                fine_hist[p][b] = 0;
            end
            for (int b = 0; b < COARSE_BINS; b++) begin
                coarse_hist[p][b] = 0;
            end
        end
    endtask

    // one accepted code with the model updated as it is offered
    task automatic send_code(input int p, input tdc_code_u c, input int gap);
        wait_ready();
        @(posedge clk);
        code_valid <= 1'b1;
        code       <= c;
        fine_hist[p][c.fine]++;
        coarse_hist[p][c.pair.coarse]++;
        @(posedge clk);
        code_valid <= 1'b0;
        repeat (gap) @(posedge clk);
    endtask

    task automatic send_frame(input int kind);
        int                     a;
        int                     p;
        int                     k;
        logic [COARSE_BITS-1:0] fav;
        tdc_code_u              c;
        // favourite window per frame gives real peaks
        lcg_state = lcg_next(lcg_state);
        fav = lcg_state[27:24];
        for (a = 0; a < ACQ_NUM; a++) begin
            for (p = 0; p < PIXEL_NUM; p++) begin
                for (k = 0; k < CODES_PER_PIXEL; k++) begin
                    lcg_state = lcg_next(lcg_state);
                    if (kind == KIND_RANDOM) begin
                        c.fine = lcg_state[31] ? {fav ^ 4'(p), lcg_state[19:16]}
                                               : lcg_state[23:16];
                    end else if (kind == KIND_SINGLE) begin
                        c.fine = 8'h5a;
                    end else begin
                        c = tie_code(p, a * CODES_PER_PIXEL + k);
                    end
                    send_code(p, c, int'(lcg_state[25:24]));
                end
            end
        end
    endtask

    // codes offered while ready is low are never entered in the model
    task automatic offer_dropped(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            if (ready) begin
                fail_run("ready high while the frame is still being processed");
            end
            @(posedge clk);
            lcg_state = lcg_next(lcg_state);
            code_valid <= 1'b1;
            code       <= lcg_state[23:16];
        end
        @(posedge clk);
        code_valid <= 1'b0;
    endtask

    task automatic check_frame();
        logic [WB_DATA_BITS-1:0] word;
        wait_frame_done();
        frames_seen++;
        bus_read(ADDR_STATUS, word);
        check_status(word, 1'b1, frames_seen);
        for (int p = 0; p < PIXEL_NUM; p++) begin
            last_results[p] = ref_result(p);
            bus_read(ADDR_RESULT_BASE + 4'(p), word);
            check_result(p, word, last_results[p]);
        end
    endtask

    task automatic run_frame(input int kind);
        send_frame(kind);
        check_frame();
        wait_ready();
        clear_model();
    endtask

    // writes leave every word alone and unmapped words read zero
    task automatic bus_checks();
        logic [WB_DATA_BITS-1:0] word;
        bus_write(ADDR_STATUS, 32'hffff_ffff);
        for (int p = 0; p < PIXEL_NUM; p++) begin
            lcg_state = lcg_next(lcg_state);
            bus_write(ADDR_RESULT_BASE + 4'(p), lcg_state);
        end
        bus_read(ADDR_STATUS, word);
        check_status(word, 1'b1, frames_seen);
        for (int p = 0; p < PIXEL_NUM; p++) begin
            bus_read(ADDR_RESULT_BASE + 4'(p), word);
            check_result(p, word, last_results[p]);
        end
        for (int a = ADDR_RESULT_BASE + PIXEL_NUM; a < (1 << WB_ADDR_BITS); a++) begin
            bus_read(4'(a), word);
            check_word($sformatf("unmapped[0x%0h]", a), word, '0);
        end
    endtask

    initial begin
        logic [WB_DATA_BITS-1:0] word;
        combin_res  = 1'b0;
        code_valid  = 1'b0;
        code        = '0;
        cyc         = 1'b0;
        stb         = 1'b0;
        we          = 1'b0;
        adr         = '0;
        dat_w       = '0;
        lcg_state   = 32'h61ee_7e83;
        frames_seen = '0;
        clear_model();
        repeat (2) @(posedge clk);
        combin_res <= 1'b1;

        // idle state after reset
        @(negedge clk);
        if (!ready) begin
            fail_run("ready low after reset");
        end
        if (frame_done) begin
            fail_run("frame_done high after reset");
        end
        bus_read(ADDR_STATUS, word);
        check_status(word, 1'b0, '0);
        for (int p = 0; p < PIXEL_NUM; p++) begin
            bus_read(ADDR_RESULT_BASE + 4'(p), word);
            check_result(p, word, '0);
        end

        repeat (4) run_frame(KIND_RANDOM);
        // one bin per pixel and then ties
        run_frame(KIND_SINGLE);
        run_frame(KIND_TIE);

        // offered during scan and during clear
        send_frame(KIND_RANDOM);
        offer_dropped(6);
        check_frame();
        offer_dropped(10);
        wait_ready();
        clear_model();
        run_frame(KIND_RANDOM);

        bus_checks();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD = 4
) (
    output logic clk
);

    // starts low, first rising edge after half a period
    initial begin
        clk = 1'b0;
    end

    always begin
        #(PERIOD / 2);
        clk = ~clk;
    end

endmodule

`default_nettype wire
